// File: Bender.yml
package:
  name: ooo_core

sources:
  - files:
      - design/ooo_pkg.sv
      - design/decode_rename.sv
      - design/issue_queue.sv
      - design/alu_execute.sv
      - design/reorder_buffer.sv
      - design/ooo_core.sv
  - target: test
    files:
      - tests/ooo_core_properties.sv
      - tests/ooo_core_tb.sv

// File: design/alu_execute.sv
//////////////////////////////////////////////////
// Single ALU. Computes the issued operation and
// broadcasts result and tag on the result bus
// one cycle after issue.
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module alu_execute import ooo_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  dispatch_t issue,
	output cdb_t      cdb
);

	word_t    opa;
	word_t    opb;
	word_t    result;

	// Bus register
	logic     cdb_valid;
	rob_tag_t cdb_tag;
	word_t    cdb_data;

	assign opa = issue.src1.value;
	assign opb = issue.src2.value;

	always_comb begin
		case (issue.op)
			ALU_ADD: result = opa + opb;
			ALU_SUB: result = opa - opb;
			ALU_AND: result = opa & opb;
			ALU_OR:  result = opa | opb;
			ALU_XOR: result = opa ^ opb;
			// Signed compare
			ALU_SLT: result = word_t'($signed(opa) < $signed(opb));
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= issue.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue.valid) begin
			cdb_tag  <= issue.tag;
			cdb_data <= result;
		end
	end

	assign cdb = '{valid: cdb_valid, tag: cdb_tag, data: cdb_data};

endmodule

`default_nettype wire

// File: design/decode_rename.sv
//////////////////////////////////////////////////
// Decode and rename stage. Turns one accepted
// instruction into a registered dispatch packet,
// renaming rd to its reorder-buffer tag and
// collecting each source from the register file,
// the reorder buffer or the result bus.
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module decode_rename import ooo_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      inst_valid,
	input  inst_t     inst,
	input  rob_tag_t  alloc_tag,
	input  cdb_t      cdb,
	input  word_t     rf_rs1,
	input  word_t     rf_rs2,
	input  logic      tag_done [2],
	input  word_t     tag_value [2],
	output arch_reg_t rs1,
	output arch_reg_t rs2,
	output rob_tag_t  query_tag [2],
	output dispatch_t dispatch
);

	// Instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	arch_reg_t  rd;
	word_t      imm_i;

	alu_op_t    op;
	logic       illegal;
	// Destination gets a tag in the alias table
	logic       renames;
	operand_t   src1;
	operand_t   src2;

	// Alias table, valid while a tag will produce the register
	logic [NUM_ARCH_REGS-1:0] alias_valid;
	rob_tag_t                 alias_tag [NUM_ARCH_REGS];

	// Dispatch register
	logic      disp_valid;
	dispatch_t disp_q;

	assign opcode  = inst[6:0];
	assign rd      = inst[11:7];
	assign funct3  = inst[14:12];
	assign rs1     = inst[19:15];
	assign rs2     = inst[24:20];
	assign funct7  = inst[31:25];
	assign imm_i   = {{20{inst[31]}}, inst[31:20]};
	// x0 stays with the register file
	assign renames = !illegal && (rd != '0);

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	always_comb begin
		op      = ALU_ADD;
		illegal = 1'b0;
		case (opcode)
			OPC_OP: begin
				case ({funct7, funct3})
					10'b0000000_000: op = ALU_ADD;
					10'b0100000_000: op = ALU_SUB;
					10'b0000000_111: op = ALU_AND;
					10'b0000000_110: op = ALU_OR;
					10'b0000000_100: op = ALU_XOR;
					10'b0000000_010: op = ALU_SLT;
					default:         illegal = 1'b1;
				endcase
			end
			// ADDI only
			OPC_OP_IMM: illegal = (funct3 != 3'b000);
			default:    illegal = 1'b1;
		endcase
	end

	// Register file, finished tag, bus this cycle, else wait
	function automatic operand_t resolve(logic renamed, rob_tag_t tag, word_t rf_val,
		logic done, word_t done_val, cdb_t bus);
		operand_t res;
		if (!renamed)
			res = '{ready: 1'b1, tag: tag, value: rf_val};
		else if (done)
			res = '{ready: 1'b1, tag: tag, value: done_val};
		else
			res = snoop_cdb('{ready: 1'b0, tag: tag, value: '0}, bus);
		return res;
	endfunction

	assign query_tag[0] = alias_tag[rs1];
	assign query_tag[1] = alias_tag[rs2];

	always_comb begin
		src1 = resolve(alias_valid[rs1], alias_tag[rs1], rf_rs1, tag_done[0],
			tag_value[0], cdb);
		if (opcode == OPC_OP_IMM)
			src2 = '{ready: 1'b1, tag: '0, value: imm_i};
		else
			src2 = resolve(alias_valid[rs2], alias_tag[rs2], rf_rs2, tag_done[1],
				tag_value[1], cdb);
	end

	//////////////////////////////////////////////////
	// Alias table and dispatch register
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			alias_valid <= '0;
			disp_valid  <= 1'b0;
		end else begin
			disp_valid <= inst_valid;
			if (inst_valid) begin
				// A recycled tag has already committed, drop back to the RF
				for (int r = 0; r < NUM_ARCH_REGS; r++)
					if (alias_tag[r] == alloc_tag)
						alias_valid[r] <= 1'b0;
				if (renames)
					alias_valid[rd] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			if (renames)
				alias_tag[rd] <= alloc_tag;
			disp_q <= '{valid: 1'b1, op: op, tag: alloc_tag, rd: rd,
				src1: src1, src2: src2, illegal: illegal};
		end
	end

	always_comb begin
		dispatch       = disp_q;
		dispatch.valid = disp_valid;
	end

endmodule

`default_nettype wire

// File: design/issue_queue.sv
//////////////////////////////////////////////////
// Issue queue. Holds dispatched ALU instructions
// in age order, wakes waiting operands from the
// result bus and hands the oldest ready entry to
// the ALU, one per cycle.
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module issue_queue import ooo_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	output dispatch_t issue
);

	// Slot 0 is always the oldest, entries kept packed toward it
	logic [WINDOW_DEPTH-1:0] slot_valid;
	dispatch_t               slot [WINDOW_DEPTH];

	// Both operands captured
	logic [WINDOW_DEPTH-1:0] ready;
	logic                    issue_fire;
	logic [TAG_W-1:0]        sel;

	// Next-state image after wakeup, removal and append
	logic [WINDOW_DEPTH-1:0] nxt_valid;
	dispatch_t               nxt_slot [WINDOW_DEPTH];

	function automatic dispatch_t wake_entry(dispatch_t e, cdb_t bus);
		dispatch_t res;
		res      = e;
		res.src1 = snoop_cdb(e.src1, bus);
		res.src2 = snoop_cdb(e.src2, bus);
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Select
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < WINDOW_DEPTH; i++)
			ready[i] = slot_valid[i] && slot[i].src1.ready && slot[i].src2.ready;
	end

	// Walk down so the lowest ready slot wins
	always_comb begin
		issue_fire = 1'b0;
		sel        = '0;
		for (int i = WINDOW_DEPTH - 1; i >= 0; i--) begin
			if (ready[i]) begin
				issue_fire = 1'b1;
				sel        = TAG_W'(i);
			end
		end
	end

	always_comb begin
		issue       = slot[sel];
		issue.valid = issue_fire;
	end

	//////////////////////////////////////////////////
	// Compact and append
	//////////////////////////////////////////////////

	always_comb begin
		int n;
		n         = 0;
		nxt_valid = '0;
		for (int i = 0; i < WINDOW_DEPTH; i++)
			nxt_slot[i] = slot[i];
		// Survivors shift down over the issued slot
		for (int i = 0; i < WINDOW_DEPTH; i++) begin
			if (slot_valid[i] && !(issue_fire && (sel == TAG_W'(i)))) begin
				nxt_slot[n]  = wake_entry(slot[i], cdb);
				nxt_valid[n] = 1'b1;
				n++;
			end
		end
		// Illegal ops go straight to the reorder buffer
		// Credits keep n below the depth here
		if (dispatch.valid && !dispatch.illegal && (n < WINDOW_DEPTH)) begin
			nxt_slot[n]  = wake_entry(dispatch, cdb);
			nxt_valid[n] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid <= '0;
		end else begin
			slot_valid <= nxt_valid;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < WINDOW_DEPTH; i++)
			slot[i] <= nxt_slot[i];
	end

endmodule

`default_nettype wire

// File: design/ooo_core.sv
//////////////////////////////////////////////////
// Top of the out-of-order core slice. Wires decode,
// issue queue, ALU and reorder buffer together.
// The source spends one credit per instruction and
// regains one on every commit.
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ooo_core import ooo_pkg::*; (
	input  logic    clock,
	input  logic    rst_n,
	input  logic    inst_valid,
	input  inst_t   inst,
	output commit_t commit
);

	// Decode to back end
	dispatch_t dispatch;
	arch_reg_t rs1;
	arch_reg_t rs2;
	rob_tag_t  query_tag [2];

	// Reorder buffer back to decode
	rob_tag_t  alloc_tag;
	word_t     rf_rs1;
	word_t     rf_rs2;
	logic      tag_done [2];
	word_t     tag_value [2];

	// Issue and result bus
	dispatch_t issue;
	cdb_t      cdb;

	decode_rename u_decode (
		.clock, .rst_n, .inst_valid, .inst, .alloc_tag, .cdb,
		.rf_rs1, .rf_rs2, .tag_done, .tag_value,
		.rs1, .rs2, .query_tag, .dispatch
	);

	issue_queue u_iq (.clock, .rst_n, .dispatch, .cdb, .issue);

	alu_execute u_alu (.clock, .rst_n, .issue, .cdb);

	reorder_buffer u_rob (
		.clock, .rst_n, .dispatch, .cdb, .rs1, .rs2, .query_tag,
		.alloc_tag, .rf_rs1, .rf_rs2, .tag_done, .tag_value, .commit
	);

endmodule

`default_nettype wire

// File: design/ooo_pkg.sv
//////////////////////////////////////////////////
// Widths, opcodes and packet types shared by the
// out-of-order integer core slice. Every RTL unit
// pulls these in by a wildcard import in its
// module header.
//////////////////////////////////////////////////

`default_nettype none

package ooo_pkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////

	// Instructions in flight, equal to the source's credits
	localparam int WINDOW_DEPTH  = 4;
	localparam int XLEN          = 32;
	localparam int NUM_ARCH_REGS = 32;
	// Reorder-buffer index width
	localparam int TAG_W         = $clog2(WINDOW_DEPTH);

	typedef logic [XLEN-1:0]                  word_t;
	typedef logic [31:0]                      inst_t;
	typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
	typedef logic [TAG_W-1:0]                 rob_tag_t;

	// RV32I major opcodes still decoded
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_t;

	//////////////////////////////////////////////////
	// Packets
	//////////////////////////////////////////////////

	// One source operand, value valid once ready is set
	typedef struct packed {
		logic     ready;
		rob_tag_t tag;
		word_t    value;
	} operand_t;

	// Decode to issue queue and reorder buffer
	typedef struct packed {
		logic      valid;
		alu_op_t   op;
		rob_tag_t  tag;
		arch_reg_t rd;
		operand_t  src1;
		operand_t  src2;
		logic      illegal;
	} dispatch_t;

	// Result bus
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		word_t    data;
	} cdb_t;

	// In-order retirement, also the credit return
	typedef struct packed {
		logic      valid;
		logic      wr_en;
		arch_reg_t rd;
		word_t     data;
		logic      illegal;
	} commit_t;

	// Capture a broadcast into a waiting operand
	function automatic operand_t snoop_cdb(operand_t op, cdb_t bus);
		operand_t res;
		res = op;
		if (!op.ready && bus.valid && (bus.tag == op.tag)) begin
			res.ready = 1'b1;
			res.value = bus.data;
		end
		return res;
	endfunction

endpackage

`default_nettype wire

// File: design/reorder_buffer.sv
//////////////////////////////////////////////////
// Reorder buffer with the architectural register
// file. Allocates one entry per dispatch, marks it
// done from the result bus and retires the head in
// program order. Also answers source lookups from
// decode.
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	input  arch_reg_t rs1,
	input  arch_reg_t rs2,
	input  rob_tag_t  query_tag [2],
	output rob_tag_t  alloc_tag,
	output word_t     rf_rs1,
	output word_t     rf_rs2,
	output logic      tag_done [2],
	output word_t     tag_value [2],
	output commit_t   commit
);

	// Pointers wrap on their own, depth is a power of two
	rob_tag_t                head;
	rob_tag_t                tail;
	logic [TAG_W:0]          count;

	// Done stays set after retirement until the slot is reused
	logic [WINDOW_DEPTH-1:0] done;
	logic [WINDOW_DEPTH-1:0] ent_illegal;
	arch_reg_t               ent_rd [WINDOW_DEPTH];
	word_t                   ent_data [WINDOW_DEPTH];

	word_t                   rf [NUM_ARCH_REGS];
	logic                    head_ready;

	// Tail skips the packet still sitting in the dispatch register
	assign alloc_tag = tail + rob_tag_t'(dispatch.valid);

	//////////////////////////////////////////////////
	// Lookups for decode
	//////////////////////////////////////////////////

	assign rf_rs1 = rf[rs1];
	assign rf_rs2 = rf[rs2];

	// A tag about to be reallocated holds old data
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			tag_done[i]  = done[query_tag[i]] &&
				!(dispatch.valid && (dispatch.tag == query_tag[i]));
			tag_value[i] = ent_data[query_tag[i]];
		end
	end

	//////////////////////////////////////////////////
	// Commit
	//////////////////////////////////////////////////

	assign head_ready = (count != '0) && done[head];

	always_comb begin
		commit.valid   = head_ready;
		commit.wr_en   = head_ready && !ent_illegal[head] && (ent_rd[head] != '0);
		commit.rd      = ent_rd[head];
		commit.data    = ent_data[head];
		commit.illegal = head_ready && ent_illegal[head];
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (dispatch.valid) begin
				tail <= tail + 1'b1;
				// Illegal entries are finished on arrival
				done[dispatch.tag] <= dispatch.illegal;
			end
			if (cdb.valid)
				done[cdb.tag] <= 1'b1;
			if (head_ready)
				head <= head + 1'b1;
			count <= count + (TAG_W+1)'(dispatch.valid) - (TAG_W+1)'(head_ready);
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		if (dispatch.valid) begin
			ent_rd[dispatch.tag]      <= dispatch.rd;
			ent_illegal[dispatch.tag] <= dispatch.illegal;
			ent_data[dispatch.tag]    <= '0;
		end
		if (cdb.valid)
			ent_data[cdb.tag] <= cdb.data;
	end

	// Architectural state starts at zero, x0 never written
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < NUM_ARCH_REGS; r++)
				rf[r] <= '0;
		end else if (commit.wr_en) begin
			rf[commit.rd] <= commit.data;
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
design/ooo_pkg.sv
design/decode_rename.sv
design/issue_queue.sv
design/alu_execute.sv
design/reorder_buffer.sv
design/ooo_core.sv
tests/ooo_core_properties.sv
tests/ooo_core_tb.sv

// File: tests/ooo_core_properties.sv
//////////////////////////////////////////////////
// Concurrent checks on core internals. Bound into
// the reorder buffer and the issue queue, each
// binding ties off the inputs it does not use.
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ooo_core_properties import ooo_pkg::*; (
	input logic      clock,
	input logic      rst_n,
	// Reorder buffer side
	input logic      alloc_req,
	input logic      full,
	input word_t     x0_value,
	// Issue queue side
	input logic      issue_valid,
	input logic      src1_ready,
	input logic      src2_ready
);

	int failure_count = 0;

	// Credits must keep allocation away from a full buffer
	no_alloc_when_full: assert property (@(posedge clock) disable iff (!rst_n)
		alloc_req |-> !full)
	else begin
		failure_count++;
		$error("allocation into a full reorder buffer");
	end

	// x0 stays hardwired to zero in the register file
	no_write_to_x0: assert property (@(posedge clock) disable iff (!rst_n)
		x0_value == '0)
	else begin
		failure_count++;
		$error("register file x0 holds a nonzero value");
	end

	issue_only_when_ready: assert property (@(posedge clock) disable iff (!rst_n)
		issue_valid |-> (src1_ready && src2_ready))
	else begin
		failure_count++;
		$error("issue with an operand not ready");
	end

endmodule

bind reorder_buffer ooo_core_properties u_rob_props (
	.clock(clock), .rst_n(rst_n),
	.alloc_req(dispatch.valid), .full(count == WINDOW_DEPTH),
	.x0_value(rf[0]),
	.issue_valid(1'b0), .src1_ready(1'b1), .src2_ready(1'b1)
);

bind issue_queue ooo_core_properties u_iq_props (
	.clock(clock), .rst_n(rst_n),
	.alloc_req(1'b0), .full(1'b0), .x0_value('0),
	.issue_valid(issue.valid), .src1_ready(issue.src1.ready), .src2_ready(issue.src2.ready)
);

`default_nettype wire

// File: tests/ooo_core_tb.sv
//////////////////////////////////////////////////
// Testbench for the out-of-order core slice.
// Sends random ALU instructions within the credit
// window, replays each commit on an in-order model
// and checks fields with immediate assertions.
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_INSTS    = 400;
	localparam int SEED         = 25;

	logic    clock;
	logic    rst_n;
	logic    inst_valid;
	inst_t   inst;
	commit_t commit;

	// Source side bookkeeping
	int      credits;
	int      sent;
	int      committed;
	int      since_reset;
	inst_t   sent_q [$];
	inst_t   next_inst;
	// Architectural state of the in-order model
	word_t   model_rf [NUM_ARCH_REGS];

	int      mismatch_count;
	int      other_count;
	int      prop_failures;

	ooo_core uut (.clock, .rst_n, .inst_valid, .inst, .commit);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// Legal ops, illegal opcodes and non-ADDI immediates, regs x0..x5 only
	function automatic inst_t random_inst();
		logic [9:0] fn [6];
		logic [6:0] bad_opc [3];
		inst_t      w;
		int unsigned kind;
		fn      = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_111,
			10'b0000000_110, 10'b0000000_100, 10'b0000000_010};
		bad_opc = '{7'b0000011, 7'b0100011, 7'b1100011};
		w           = inst_t'($urandom());
		w[11:7]     = 5'($urandom_range(0, 5));
		w[19:15]    = 5'($urandom_range(0, 5));
		kind        = $urandom_range(0, 9);
		if (kind == 0) begin
			w[6:0] = bad_opc[$urandom_range(0, 2)];
		end else if (kind == 1) begin
			w[6:0]   = OPC_OP_IMM;
			w[14:12] = 3'($urandom_range(1, 7));
		end else if (kind < 5) begin
			// ADDI, upper bits stay random as the immediate
			w[6:0]   = OPC_OP_IMM;
			w[14:12] = 3'b000;
		end else begin
			w[6:0]                = OPC_OP;
			w[24:20]              = 5'($urandom_range(0, 5));
			{w[31:25], w[14:12]}  = fn[$urandom_range(0, 5)];
		end
		return w;
	endfunction

	// Sequential RV32I semantics on the model register file
	task automatic model_exec(input inst_t i, output logic legal, output word_t value);
		word_t a;
		word_t b;
		a     = model_rf[i[19:15]];
		b     = model_rf[i[24:20]];
		legal = 1'b1;
		value = '0;
		if (i[6:0] == OPC_OP_IMM && i[14:12] == 3'b000)
			value = a + {{20{i[31]}}, i[31:20]};
		else if (i[6:0] == OPC_OP)
			case ({i[31:25], i[14:12]})
				10'b0000000_000: value = a + b;
				10'b0100000_000: value = a - b;
				10'b0000000_111: value = a & b;
				10'b0000000_110: value = a | b;
				10'b0000000_100: value = a ^ b;
				10'b0000000_010: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default:         legal = 1'b0;
			endcase
		else
			legal = 1'b0;
		if (legal && i[11:7] != 5'd0)
			model_rf[i[11:7]] = value;
	endtask

	task automatic compare_field(input string name, input word_t expected, input word_t actual);
		assert (actual === expected) else begin
			mismatch_count++;
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_commit();
		inst_t i;
		logic  legal;
		word_t value;
		logic  exp_wr;
		credits++;
		committed++;
		assert (credits <= WINDOW_DEPTH) else begin
			other_count++;
			$display("more credits returned than spent at %0t", $time);
		end
		if (sent_q.size() == 0) begin
			other_count++;
			$display("commit at %0t with no instruction outstanding", $time);
			return;
		end
		i = sent_q.pop_front();
		model_exec(i, legal, value);
		exp_wr = legal && (i[11:7] != 5'd0);
		compare_field("commit.illegal", word_t'(!legal), word_t'(commit.illegal));
		compare_field("commit.wr_en", word_t'(exp_wr), word_t'(commit.wr_en));
		compare_field("commit.rd", word_t'(i[11:7]), word_t'(commit.rd));
		if (legal)
			compare_field("commit.data", value, commit.data);
	endtask

	// Outputs sampled mid-cycle, away from the driving edge
	always @(negedge clock) begin
		if (!rst_n)
			since_reset = 0;
		else
			since_reset++;
		if (since_reset <= 1)
			assert (!commit.valid) else begin
				other_count++;
				$display("commit valid during or right after reset at %0t", $time);
			end
		if (rst_n && since_reset > 1 && commit.valid)
			check_commit();
	end

	// Watchdog sized from the instruction count
	initial begin
		#(NUM_INSTS * 20 * CLK_PERIOD);
		$display("timeout: core did not drain %0d instructions in time", NUM_INSTS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		clock          = 1'b0;
		rst_n          = 1'b0;
		inst_valid     = 1'b0;
		inst           = '0;
		credits        = WINDOW_DEPTH;
		sent           = 0;
		committed      = 0;
		since_reset    = 0;
		mismatch_count = 0;
		other_count    = 0;
		foreach (model_rf[r])
			model_rf[r] = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1;

		// Send only while a credit is held, with random idle cycles
		while (sent < NUM_INSTS) begin
			@(posedge clock);
			if (credits > 0 && $urandom_range(0, 3) != 0) begin
				next_inst = random_inst();
				inst_valid <= 1'b1;
				inst       <= next_inst;
				sent_q.push_back(next_inst);
				credits--;
				sent++;
			end else begin
				inst_valid <= 1'b0;
			end
		end
		@(posedge clock);
		inst_valid <= 1'b0;

		// Drain, then make sure nothing else retires
		wait (committed == sent);
		repeat (10) @(posedge clock);
		assert (credits == WINDOW_DEPTH) else begin
			other_count++;
			$display("credits after drain are %0d, not all returned", credits);
		end
		assert (committed == sent && sent_q.size() == 0) else begin
			other_count++;
			$display("sent %0d instructions but %0d committed", sent, committed);
		end

		prop_failures = uut.u_rob.u_rob_props.failure_count +
			uut.u_iq.u_iq_props.failure_count;
		$display("errors: %0d mismatches, %0d other, %0d property failures; sent %0d, committed %0d",
			mismatch_count, other_count, prop_failures, sent, committed);
		if (mismatch_count == 0 && other_count == 0 && prop_failures == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
